// File: project.f
lsu_pkg.sv
ex_stage.sv
mem_stage.sv
wb_stage.sv
data_sram.sv
lsu_top.sv
tb_lsu_top.sv

// File: tb_lsu_top.sv
`default_nettype none

module tb_lsu_top;
    import lsu_pkg::*;

    localparam int NUM_ENTRIES     = 24;
    localparam int BURST_START     = 8;    // entries from here on go back to back
    localparam int CLK_PERIOD      = 100;
    localparam int WATCHDOG_CYCLES = NUM_ENTRIES * (8 + DSRAM_LATENCY) + 8;

    logic     clk;
    logic     resetn;
    logic     in_valid;
    logic     in_allowin;
    lsu_op_e  in_op;
    reg_idx_t in_rd;
    word_t    in_base;
    word_t    in_offset;
    word_t    in_store_data;
    logic     retire_valid;
    logic     retire_we;
    reg_idx_t retire_waddr;
    word_t    retire_wdata;

    // stimulus table, one row per operation
    string    tbl_name   [NUM_ENTRIES];
    lsu_op_e  tbl_op     [NUM_ENTRIES];
    reg_idx_t tbl_rd     [NUM_ENTRIES];
    word_t    tbl_base   [NUM_ENTRIES];
    word_t    tbl_offset [NUM_ENTRIES];
    word_t    tbl_data   [NUM_ENTRIES];
    logic     tbl_we     [NUM_ENTRIES];  // expected write enable
    word_t    exp_wdata  [NUM_ENTRIES];  // filled from the model when applied
    int       n_entries;

    word_t       model_mem [0:1023];
    int          pending [$];            // entry indices in retire order
    int          retired;
    logic [15:0] lfsr;

    lsu_top DUT (
        .clk           (clk),
        .resetn        (resetn),
        .in_valid      (in_valid),
        .in_allowin    (in_allowin),
        .in_op         (in_op),
        .in_rd         (in_rd),
        .in_base       (in_base),
        .in_offset     (in_offset),
        .in_store_data (in_store_data),
        .retire_valid  (retire_valid),
        .retire_we     (retire_we),
        .retire_waddr  (retire_waddr),
        .retire_wdata  (retire_wdata)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic table_entry(input string name, input lsu_op_e op, input reg_idx_t rd,
                               input word_t base, input word_t offset, input word_t data,
                               input logic we);
        tbl_name[n_entries]   = name;
        tbl_op[n_entries]     = op;
        tbl_rd[n_entries]     = rd;
        tbl_base[n_entries]   = base;
        tbl_offset[n_entries] = offset;
        tbl_data[n_entries]   = data;
        tbl_we[n_entries]     = we;
        n_entries++;
    endtask

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            $display("Result: FAILED");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    // galois lfsr, one step per bit
    function automatic logic random_bit();
        logic b;
        b    = lfsr[0];
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        return b;
    endfunction

    // lane taken from the word, then sign or zero filled
    function automatic word_t load_value(input lsu_op_e op, input word_t w, input logic [1:0] off);
        word_t lane;
        lane = w >> (8 * off);
        case (op)
            OP_LD_B:  return {{24{lane[7]}}, lane[7:0]};
            OP_LD_BU: return {24'h0, lane[7:0]};
            OP_LD_H:  return {{16{lane[15]}}, lane[15:0]};
            OP_LD_HU: return {16'h0, lane[15:0]};
            default:  return w;
        endcase
    endfunction

    // memory model and expected result, in input order
    task automatic apply_model(input int i);
        addr_t      a;
        logic [9:0] w;
        logic [1:0] off;
        a   = tbl_base[i] + tbl_offset[i];
        w   = a[11:2];
        off = a[1:0];
        exp_wdata[i] = a;
        case (tbl_op[i])
            OP_ADDI: ;
            OP_ST_B: model_mem[w][8*off +: 8]  = tbl_data[i][7:0];
            OP_ST_H: model_mem[w][8*off +: 16] = tbl_data[i][15:0];
            OP_ST_W: model_mem[w] = tbl_data[i];
            default: exp_wdata[i] = load_value(tbl_op[i], model_mem[w], off);
        endcase
        pending.push_back(i);
    endtask

    always @(negedge clk) begin : retire_monitor
        int idx;
        if (resetn && retire_valid) begin
            if (pending.size() == 0) begin
                $display("an operation retired with nothing left in flight");
                $display("Result: FAILED");
                $fatal(1, "unexpected retire");
            end else begin
                idx = pending.pop_front();
                check_value({tbl_name[idx], " we"}, word_t'(tbl_we[idx]), word_t'(retire_we));
                if (tbl_we[idx]) begin
                    check_value({tbl_name[idx], " waddr"}, word_t'(tbl_rd[idx]),
                                word_t'(retire_waddr));
                    check_value({tbl_name[idx], " wdata"}, exp_wdata[idx], retire_wdata);
                end
                retired++;
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout, pipeline stopped retiring after %0d of %0d operations",
                 retired, NUM_ENTRIES);
        $display("Result: FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        logic b0;
        logic b1;
        int   idle;
        clk           = 1'b0;
        resetn        = 1'b0;
        in_valid      = 1'b0;
        in_op         = OP_ADDI;
        in_rd         = '0;
        in_base       = '0;
        in_offset     = '0;
        in_store_data = '0;
        lfsr          = 16'd29;
        n_entries     = 0;
        retired       = 0;
        for (int k = 0; k < 1024; k++) begin
            model_mem[k] = '0;  // sram clears at reset
        end

        table_entry("addi_basic",      OP_ADDI,  5'd1,  32'h1234_0000, 32'h0000_5678, 32'h0, 1'b1);
        table_entry("addi_neg_offset", OP_ADDI,  5'd2,  32'h0000_0100, 32'hFFFF_FFF0, 32'h0, 1'b1);
        table_entry("addi_r0",         OP_ADDI,  5'd0,  32'h0000_0040, 32'h0000_0004, 32'h0, 1'b0);
        table_entry("st_w_200",        OP_ST_W,  5'd7,  32'h200, 32'h0,  32'h89AB_CDEF, 1'b0);
        table_entry("ld_w_200",        OP_LD_W,  5'd3,  32'h1F0, 32'h10, 32'h0, 1'b1);
        table_entry("st_b_201",        OP_ST_B,  5'd0,  32'h200, 32'h1,  32'hFFFF_FF55, 1'b0);
        table_entry("st_h_202",        OP_ST_H,  5'd0,  32'h200, 32'h2,  32'hABCD_1234, 1'b0);
        table_entry("ld_w_merged",     OP_LD_W,  5'd4,  32'h200, 32'h0,  32'h0, 1'b1);
        table_entry("st_w_300",        OP_ST_W,  5'd0,  32'h300, 32'h0,  32'h80FF_7F01, 1'b0);
        table_entry("ld_b_300",        OP_LD_B,  5'd8,  32'h300, 32'h0,  32'h0, 1'b1);
        table_entry("ld_b_301",        OP_LD_B,  5'd9,  32'h300, 32'h1,  32'h0, 1'b1);
        table_entry("ld_b_302",        OP_LD_B,  5'd10, 32'h300, 32'h2,  32'h0, 1'b1);
        table_entry("ld_b_303",        OP_LD_B,  5'd11, 32'h300, 32'h3,  32'h0, 1'b1);
        table_entry("ld_bu_300",       OP_LD_BU, 5'd12, 32'h300, 32'h0,  32'h0, 1'b1);
        table_entry("ld_bu_301",       OP_LD_BU, 5'd13, 32'h300, 32'h1,  32'h0, 1'b1);
        table_entry("ld_bu_302",       OP_LD_BU, 5'd14, 32'h300, 32'h2,  32'h0, 1'b1);
        table_entry("ld_bu_303",       OP_LD_BU, 5'd15, 32'h300, 32'h3,  32'h0, 1'b1);
        table_entry("st_w_304",        OP_ST_W,  5'd0,  32'h304, 32'h0,  32'h8001_FFFE, 1'b0);
        table_entry("ld_h_304",        OP_LD_H,  5'd16, 32'h300, 32'h4,  32'h0, 1'b1);
        table_entry("ld_hu_304",       OP_LD_HU, 5'd17, 32'h300, 32'h4,  32'h0, 1'b1);
        table_entry("ld_h_306",        OP_LD_H,  5'd18, 32'h300, 32'h6,  32'h0, 1'b1);
        table_entry("ld_hu_306",       OP_LD_HU, 5'd19, 32'h300, 32'h6,  32'h0, 1'b1);
        table_entry("st_b_307",        OP_ST_B,  5'd0,  32'h304, 32'h3,  32'h0000_00AA, 1'b0);
        table_entry("ld_w_304",        OP_LD_W,  5'd20, 32'h304, 32'h0,  32'h0, 1'b1);

        repeat (8) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;

        for (int i = 0; i < NUM_ENTRIES; i++) begin
            while (!in_allowin) @(negedge clk);  // ex stage still holding
            in_valid      = 1'b1;
            in_op         = tbl_op[i];
            in_rd         = tbl_rd[i];
            in_base       = tbl_base[i];
            in_offset     = tbl_offset[i];
            in_store_data = tbl_data[i];
            apply_model(i);
            @(negedge clk);  // taken at the posedge just passed
            in_valid = 1'b0;
            if (i < BURST_START) begin
                b0   = random_bit();
                b1   = random_bit();
                idle = {b1, b0};
            end else begin
                idle = 0;
            end
            repeat (idle) @(negedge clk);
        end

        wait (retired == NUM_ENTRIES);
        repeat (4) @(negedge clk);  // room for a duplicate retire to show up

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: lsu_top.sv
`default_nettype none

module lsu_top (
    input  logic              clk,
    input  logic              resetn,
    input  logic              in_valid,
    output logic              in_allowin,
    input  lsu_pkg::lsu_op_e  in_op,
    input  lsu_pkg::reg_idx_t in_rd,
    input  lsu_pkg::word_t    in_base,
    input  lsu_pkg::word_t    in_offset,
    input  lsu_pkg::word_t    in_store_data,
    output logic              retire_valid,
    output logic              retire_we,
    output lsu_pkg::reg_idx_t retire_waddr,
    output lsu_pkg::word_t    retire_wdata
);
    import lsu_pkg::*;

    // ex to mem
    logic     ex_to_mem_valid;
    logic     mem_allowin;
    lsu_op_e  ex_op;
    reg_idx_t ex_rd;
    word_t    ex_addr_result;

    // mem to wb
    logic     mem_to_wb_valid;
    logic     wb_allowin;
    logic     mem_rf_we;
    reg_idx_t mem_rf_waddr;
    word_t    mem_rf_wdata;

    // sram port
    logic     sram_req;
    logic     sram_wr;
    strb_t    sram_strb;
    addr_t    sram_addr;
    word_t    sram_wdata;
    logic     sram_addr_ok;
    logic     sram_data_ok;
    word_t    sram_rdata;

    ex_stage u_ex_stage (
        .clk             (clk),
        .resetn          (resetn),
        .in_valid        (in_valid),
        .in_allowin      (in_allowin),
        .in_op           (in_op),
        .in_rd           (in_rd),
        .in_base         (in_base),
        .in_offset       (in_offset),
        .in_store_data   (in_store_data),
        .mem_allowin     (mem_allowin),
        .ex_to_mem_valid (ex_to_mem_valid),
        .ex_op           (ex_op),
        .ex_rd           (ex_rd),
        .ex_addr_result  (ex_addr_result),
        .sram_req        (sram_req),
        .sram_wr         (sram_wr),
        .sram_strb       (sram_strb),
        .sram_addr       (sram_addr),
        .sram_wdata      (sram_wdata),
        .sram_addr_ok    (sram_addr_ok)
    );

    mem_stage u_mem_stage (
        .clk             (clk),
        .resetn          (resetn),
        .ex_to_mem_valid (ex_to_mem_valid),
        .mem_allowin     (mem_allowin),
        .ex_op           (ex_op),
        .ex_rd           (ex_rd),
        .ex_addr_result  (ex_addr_result),
        .wb_allowin      (wb_allowin),
        .sram_data_ok    (sram_data_ok),
        .sram_rdata      (sram_rdata),
        .mem_to_wb_valid (mem_to_wb_valid),
        .mem_rf_we       (mem_rf_we),
        .mem_rf_waddr    (mem_rf_waddr),
        .mem_rf_wdata    (mem_rf_wdata)
    );

    wb_stage u_wb_stage (
        .clk             (clk),
        .resetn          (resetn),
        .mem_to_wb_valid (mem_to_wb_valid),
        .mem_rf_we       (mem_rf_we),
        .mem_rf_waddr    (mem_rf_waddr),
        .mem_rf_wdata    (mem_rf_wdata),
        .wb_allowin      (wb_allowin),
        .retire_valid    (retire_valid),
        .retire_we       (retire_we),
        .retire_waddr    (retire_waddr),
        .retire_wdata    (retire_wdata)
    );

    data_sram u_data_sram (
        .clk     (clk),
        .resetn  (resetn),
        .req     (sram_req),
        .wr      (sram_wr),
        .strb    (sram_strb),
        .addr    (sram_addr),
        .wdata   (sram_wdata),
        .addr_ok (sram_addr_ok),
        .data_ok (sram_data_ok),
        .rdata   (sram_rdata)
    );

endmodule

`default_nettype wire

// File: data_sram.sv
`default_nettype none

module data_sram (
    input  logic           clk,
    input  logic           resetn,
    input  logic           req,
    input  logic           wr,
    input  lsu_pkg::strb_t strb,
    input  lsu_pkg::addr_t addr,
    input  lsu_pkg::word_t wdata,
    output logic           addr_ok,
    output logic           data_ok,
    output lsu_pkg::word_t rdata
);
    import lsu_pkg::*;

    word_t                       mem [0:(1 << DSRAM_DEPTH_LOG2) - 1];
    logic                        busy;     // one request in flight
    logic [DSRAM_CNT_W-1:0]      cnt;
    logic [DSRAM_DEPTH_LOG2-1:0] idx;
    logic [DSRAM_DEPTH_LOG2-1:0] rd_idx;
    logic                        accept;

    assign idx     = addr[DSRAM_DEPTH_LOG2+1:2];  // word index
    assign addr_ok = ~busy;
    assign accept  = req & addr_ok;

    // latency countdown, data_ok in the cycle it runs out
    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy    <= 1'b0;
            cnt     <= '0;
            data_ok <= 1'b0;
        end else begin
            data_ok <= 1'b0;
            if (accept) begin
                busy <= 1'b1;
                cnt  <= DSRAM_CNT_W'(DSRAM_LATENCY);
            end else if (busy) begin
                if (cnt == DSRAM_CNT_W'(1)) begin
                    busy    <= 1'b0;
                    data_ok <= 1'b1;
                end else begin
                    cnt <= cnt - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rd_idx <= idx;
        end
        if (busy && cnt == DSRAM_CNT_W'(1)) begin
            rdata <= mem[rd_idx];  // reads see writes made at acceptance
        end
    end

    // byte lanes written when the request is taken
    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < (1 << DSRAM_DEPTH_LOG2); i++) begin
                mem[i] <= '0;
            end
        end else if (accept && wr) begin
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) begin
                    mem[idx][b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
    end

    // a request turned away must be presented again unchanged
    a_req_stable: assert property (@(posedge clk) disable iff (!resetn)
        (req && !addr_ok) |=> (!req || $stable(addr)));

endmodule

`default_nettype wire

// File: wb_stage.sv
`default_nettype none

module wb_stage (
    input  logic              clk,
    input  logic              resetn,
    input  logic              mem_to_wb_valid,
    input  logic              mem_rf_we,
    input  lsu_pkg::reg_idx_t mem_rf_waddr,
    input  lsu_pkg::word_t    mem_rf_wdata,
    output logic              wb_allowin,
    output logic              retire_valid,
    output logic              retire_we,
    output lsu_pkg::reg_idx_t retire_waddr,
    output lsu_pkg::word_t    retire_wdata
);
    import lsu_pkg::*;

    logic     wb_valid;
    logic     wb_we;
    reg_idx_t wb_waddr;
    word_t    wb_wdata;

    assign wb_allowin = 1'b1;  // last stage, always ready to go

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_valid <= 1'b0;
        end else if (wb_allowin) begin
            wb_valid <= mem_to_wb_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_to_wb_valid && wb_allowin) begin
            wb_we    <= mem_rf_we;
            wb_waddr <= mem_rf_waddr;
            wb_wdata <= mem_rf_wdata;
        end
    end

    assign retire_valid = wb_valid;
    assign retire_we    = wb_valid & wb_we & (wb_waddr != 5'd0);  // r0 stays zero
    assign retire_waddr = wb_waddr;
    assign retire_wdata = wb_wdata;

endmodule

`default_nettype wire

// File: mem_stage.sv
`default_nettype none

module mem_stage (
    input  logic              clk,
    input  logic              resetn,
    input  logic              ex_to_mem_valid,
    output logic              mem_allowin,
    input  lsu_pkg::lsu_op_e  ex_op,
    input  lsu_pkg::reg_idx_t ex_rd,
    input  lsu_pkg::word_t    ex_addr_result,
    input  logic              wb_allowin,
    input  logic              sram_data_ok,
    input  lsu_pkg::word_t    sram_rdata,
    output logic              mem_to_wb_valid,
    output logic              mem_rf_we,
    output lsu_pkg::reg_idx_t mem_rf_waddr,
    output lsu_pkg::word_t    mem_rf_wdata
);
    import lsu_pkg::*;

    logic        mem_valid;
    logic        mem_requed;  // sram request still outstanding
    logic        mem_ready_go;
    lsu_op_e     mem_op;
    reg_idx_t    mem_rd;
    word_t       mem_addr_result;
    logic [7:0]  byte_sel;
    logic [15:0] half_sel;
    word_t       load_data;

    assign mem_ready_go    = ~mem_requed | sram_data_ok;
    assign mem_allowin     = ~mem_valid | mem_ready_go & wb_allowin;
    assign mem_to_wb_valid = mem_valid & mem_ready_go;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mem_valid <= 1'b0;
        end else if (mem_allowin) begin
            mem_valid <= ex_to_mem_valid;
        end
    end

    // a memory op enters on the same edge its request is accepted
    always_ff @(posedge clk) begin
        if (!resetn) begin
            mem_requed <= 1'b0;
        end else if (ex_to_mem_valid && mem_allowin) begin
            mem_requed <= is_mem_op(ex_op);
        end else if (sram_data_ok) begin
            mem_requed <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_to_mem_valid && mem_allowin) begin
            mem_op          <= ex_op;
            mem_rd          <= ex_rd;
            mem_addr_result <= ex_addr_result;
        end
    end

    // lane pick by the low address bits
    always_comb begin
        case (mem_addr_result[1:0])
            2'd0:    byte_sel = sram_rdata[7:0];
            2'd1:    byte_sel = sram_rdata[15:8];
            2'd2:    byte_sel = sram_rdata[23:16];
            default: byte_sel = sram_rdata[31:24];
        endcase
    end

    assign half_sel = mem_addr_result[1] ? sram_rdata[31:16] : sram_rdata[15:0];

    always_comb begin
        case (mem_op)
            OP_LD_B:  load_data = {{24{byte_sel[7]}}, byte_sel};
            OP_LD_BU: load_data = {24'd0, byte_sel};
            OP_LD_H:  load_data = {{16{half_sel[15]}}, half_sel};
            OP_LD_HU: load_data = {16'd0, half_sel};
            default:  load_data = sram_rdata;  // word load
        endcase
    end

    // stores write no register
    assign mem_rf_we    = mem_valid & (mem_op == OP_ADDI || is_load_op(mem_op));
    assign mem_rf_waddr = mem_rd;
    assign mem_rf_wdata = is_load_op(mem_op) ? load_data : mem_addr_result;

    // the sram only answers a request this stage is holding
    a_no_stray_data_ok: assert property (@(posedge clk) disable iff (!resetn)
        sram_data_ok |-> mem_valid && mem_requed);

endmodule

`default_nettype wire

// File: ex_stage.sv
`default_nettype none

module ex_stage (
    input  logic              clk,
    input  logic              resetn,
    input  logic              in_valid,
    output logic              in_allowin,
    input  lsu_pkg::lsu_op_e  in_op,
    input  lsu_pkg::reg_idx_t in_rd,
    input  lsu_pkg::word_t    in_base,
    input  lsu_pkg::word_t    in_offset,
    input  lsu_pkg::word_t    in_store_data,
    input  logic              mem_allowin,
    output logic              ex_to_mem_valid,
    output lsu_pkg::lsu_op_e  ex_op,
    output lsu_pkg::reg_idx_t ex_rd,
    output lsu_pkg::word_t    ex_addr_result,
    output logic              sram_req,
    output logic              sram_wr,
    output lsu_pkg::strb_t    sram_strb,
    output lsu_pkg::addr_t    sram_addr,
    output lsu_pkg::word_t    sram_wdata,
    input  logic              sram_addr_ok
);
    import lsu_pkg::*;

    logic  ex_valid;
    logic  ex_ready_go;
    logic  ex_is_mem;
    logic  ex_is_half;
    logic  ex_is_word;
    word_t ex_base;
    word_t ex_offset;
    word_t ex_store_data;
    addr_t ex_addr;

    assign ex_is_mem  = is_mem_op(ex_op);
    assign ex_is_half = is_half_op(ex_op);
    assign ex_is_word = is_word_op(ex_op);

    // memory ops leave only once the sram has taken the request
    assign ex_ready_go     = ex_is_mem ? sram_addr_ok : 1'b1;
    assign in_allowin      = ~ex_valid | ex_ready_go & mem_allowin;
    assign ex_to_mem_valid = ex_valid & ex_ready_go;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ex_valid <= 1'b0;
        end else if (in_allowin) begin
            ex_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            ex_op         <= in_op;
            ex_rd         <= in_rd;
            ex_base       <= in_base;
            ex_offset     <= in_offset;
            ex_store_data <= in_store_data;
        end
    end

    assign ex_addr        = ex_base + ex_offset;
    assign ex_addr_result = ex_addr;

    // request only when mem can take the op on the same edge
    assign sram_req  = ex_valid & ex_is_mem & mem_allowin;
    assign sram_wr   = is_store_op(ex_op);
    assign sram_addr = ex_addr;

    always_comb begin
        if (!is_store_op(ex_op)) begin
            sram_strb = 4'b0000;  // loads write nothing
        end else if (ex_is_word) begin
            sram_strb = 4'b1111;
        end else if (ex_is_half) begin
            sram_strb = ex_addr[1] ? 4'b1100 : 4'b0011;
        end else begin
            sram_strb = 4'b0001 << ex_addr[1:0];
        end
    end

    // replicate store data so every lane carries it
    always_comb begin
        if (ex_is_word) begin
            sram_wdata = ex_store_data;
        end else if (ex_is_half) begin
            sram_wdata = {2{ex_store_data[15:0]}};
        end else begin
            sram_wdata = {4{ex_store_data[7:0]}};
        end
    end

    // an accepted access must be naturally aligned
    a_aligned_access: assert property (@(posedge clk) disable iff (!resetn)
        (sram_req && sram_addr_ok) |-> !(ex_is_half && ex_addr[0])
                                       && !(ex_is_word && ex_addr[1:0] != 2'b00));

endmodule

`default_nettype wire

// File: lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    // data memory timing and size
    localparam int DSRAM_LATENCY    = 2;   // accept to data_ok, in cycles
    localparam int DSRAM_DEPTH_LOG2 = 10;  // 1024 words
    localparam int DSRAM_CNT_W      = $clog2(DSRAM_LATENCY + 1);

    typedef logic [31:0] word_t;     // data word
    typedef logic [31:0] addr_t;     // byte address
    typedef logic [4:0]  reg_idx_t;  // gpr index
    typedef logic [3:0]  strb_t;     // byte write enables

    typedef enum logic [3:0] {
        OP_ADDI  = 4'd0,  // rd = base + offset
        OP_LD_B  = 4'd1,
        OP_LD_BU = 4'd2,
        OP_LD_H  = 4'd3,
        OP_LD_HU = 4'd4,
        OP_LD_W  = 4'd5,
        OP_ST_B  = 4'd6,
        OP_ST_H  = 4'd7,
        OP_ST_W  = 4'd8
    } lsu_op_e;

    // op class helpers, shared by ex and mem stages
    function automatic logic is_load_op(lsu_op_e op);
        return op inside {OP_LD_B, OP_LD_BU, OP_LD_H, OP_LD_HU, OP_LD_W};
    endfunction

    function automatic logic is_store_op(lsu_op_e op);
        return op inside {OP_ST_B, OP_ST_H, OP_ST_W};
    endfunction

    function automatic logic is_mem_op(lsu_op_e op);
        return is_load_op(op) | is_store_op(op);
    endfunction

    // access size, byte accesses are neither
    function automatic logic is_half_op(lsu_op_e op);
        return op inside {OP_LD_H, OP_LD_HU, OP_ST_H};
    endfunction

    function automatic logic is_word_op(lsu_op_e op);
        return op inside {OP_LD_W, OP_ST_W};
    endfunction

endpackage

`default_nettype wire
